//--- hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    // word address, byte offset dropped
    localparam int mem_addr_w = 14;

    // --------------------------------------------------
    // opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    // --------------------------------------------------
    // alu operations
    localparam int alu_op_w = 3;
    localparam logic [alu_op_w-1:0] alu_add    = 3'd0;
    localparam logic [alu_op_w-1:0] alu_sub    = 3'd1;
    localparam logic [alu_op_w-1:0] alu_and    = 3'd2;
    localparam logic [alu_op_w-1:0] alu_or     = 3'd3;
    localparam logic [alu_op_w-1:0] alu_xor    = 3'd4;
    localparam logic [alu_op_w-1:0] alu_slt    = 3'd5;
    localparam logic [alu_op_w-1:0] alu_pass_b = 3'd6;

    // writeback source
    localparam int wb_sel_w = 2;
    localparam logic [wb_sel_w-1:0] wb_alu  = 2'd0;
    localparam logic [wb_sel_w-1:0] wb_mem  = 2'd1;
    localparam logic [wb_sel_w-1:0] wb_link = 2'd2;

    // operand forwarding source
    localparam int fwd_sel_w = 2;
    localparam logic [fwd_sel_w-1:0] fwd_none = 2'd0;
    localparam logic [fwd_sel_w-1:0] fwd_mem  = 2'd1;
    localparam logic [fwd_sel_w-1:0] fwd_wb   = 2'd2;

    // --------------------------------------------------
    // instruction format views
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
    } instr_t;

endpackage

`default_nettype wire

//--- hdl/hazard_if.sv
`default_nettype none

interface hazard_if;

    // decode
    logic [cpu_pkg::reg_addr_w-1:0] rs1_id;
    logic [cpu_pkg::reg_addr_w-1:0] rs2_id;
    logic                           id_uses_rs2;
    // execute
    logic [cpu_pkg::reg_addr_w-1:0] rd_ex;
    logic                           load_ex;
    logic [cpu_pkg::reg_addr_w-1:0] rs1_ex;
    logic [cpu_pkg::reg_addr_w-1:0] rs2_ex;
    logic                           redirect;
    // memory and writeback
    logic [cpu_pkg::reg_addr_w-1:0] rd_mem;
    logic                           we_mem;
    logic [cpu_pkg::reg_addr_w-1:0] rd_wb;
    logic                           we_wb;
    // control back to the stages
    logic                           stall;
    logic                           flush;
    logic [cpu_pkg::fwd_sel_w-1:0]  fwd_a;
    logic [cpu_pkg::fwd_sel_w-1:0]  fwd_b;

    modport ctrl (
        input  rs1_id, rs2_id, id_uses_rs2, rd_ex, load_ex, rs1_ex, rs2_ex, redirect,
        input  rd_mem, we_mem, rd_wb, we_wb,
        output stall, flush, fwd_a, fwd_b
    );
    modport dec (output rs1_id, rs2_id, id_uses_rs2, input stall, flush);
    modport ex (output rd_ex, load_ex, rs1_ex, rs2_ex, redirect, input fwd_a, fwd_b);
    modport mem (output rd_mem, we_mem, rd_wb, we_wb);

endinterface

`default_nettype wire

//--- hdl/pipe_control.sv
`default_nettype none

module pipe_control (
    hazard_if.ctrl hz
);

    // nearest producer wins, x0 never forwards
    function automatic logic [cpu_pkg::fwd_sel_w-1:0] fwd_pick(
        input logic [cpu_pkg::reg_addr_w-1:0] src,
        input logic                           we_mem,
        input logic [cpu_pkg::reg_addr_w-1:0] rd_mem,
        input logic                           we_wb,
        input logic [cpu_pkg::reg_addr_w-1:0] rd_wb
    );
        if (we_mem && rd_mem != '0 && rd_mem == src) begin
            return cpu_pkg::fwd_mem;
        end else if (we_wb && rd_wb != '0 && rd_wb == src) begin
            return cpu_pkg::fwd_wb;
        end else begin
            return cpu_pkg::fwd_none;
        end
    endfunction

    // --------------------------------------------------
    // load-use hazard

    logic rs1_hit;
    logic rs2_hit;

    assign rs1_hit = (hz.rd_ex == hz.rs1_id);
    assign rs2_hit = hz.id_uses_rs2 && (hz.rd_ex == hz.rs2_id);

    // load result only exists after the memory stage
    assign hz.stall = hz.load_ex && (hz.rd_ex != '0) && (rs1_hit || rs2_hit);

    // taken branch or jump squashes fetch and decode
    assign hz.flush = hz.redirect;

    assign hz.fwd_a = fwd_pick(hz.rs1_ex, hz.we_mem, hz.rd_mem, hz.we_wb, hz.rd_wb);
    assign hz.fwd_b = fwd_pick(hz.rs2_ex, hz.we_mem, hz.rd_mem, hz.we_wb, hz.rd_wb);

endmodule

`default_nettype wire

//--- hdl/fetch_stage.sv
`default_nettype none

module fetch_stage (
    input  wire                             clk,
    input  wire                             rst,
    input  wire  [cpu_pkg::xlen-1:0]        im_rdata,
    input  wire  [cpu_pkg::xlen-1:0]        redirect_pc,
    hazard_if.dec                           hz,
    output logic [cpu_pkg::mem_addr_w-1:0]  im_addr,
    output logic [cpu_pkg::xlen-1:0]        pc_id,
    output logic [cpu_pkg::xlen-1:0]        instr_id
);

    logic [cpu_pkg::xlen-1:0] pc;
    logic [cpu_pkg::xlen-1:0] pc_next;

    // flush beats stall
    always_comb begin
        if (hz.flush) begin
            pc_next = redirect_pc;
        end else if (hz.stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + cpu_pkg::xlen'(4);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign im_addr = pc[cpu_pkg::mem_addr_w+1:2];

    // --------------------------------------------------
    // fetch/decode register
    // all-zero word decodes as a no-op bubble
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_id    <= '0;
            instr_id <= '0;
        end else if (hz.flush) begin
            instr_id <= '0;
        end else if (!hz.stall) begin
            pc_id    <= pc;
            instr_id <= im_rdata;
        end
    end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`default_nettype none

module reg_file (
    input  wire                              clk,
    input  wire                              rst,
    input  wire  [cpu_pkg::reg_addr_w-1:0]   rs1,
    input  wire  [cpu_pkg::reg_addr_w-1:0]   rs2,
    input  wire                              wb_we,
    input  wire  [cpu_pkg::reg_addr_w-1:0]   wb_rd,
    input  wire  [cpu_pkg::xlen-1:0]         wb_data,
    output logic [cpu_pkg::xlen-1:0]         rd1,
    output logic [cpu_pkg::xlen-1:0]         rd2
);

    // x0 has no storage
    logic [cpu_pkg::xlen-1:0] regs [1:31];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // same-cycle write passes straight through
    function automatic logic [cpu_pkg::xlen-1:0] read_port(
        input logic [cpu_pkg::reg_addr_w-1:0] a
    );
        if (a == '0) begin
            return '0;
        end else if (wb_we && a == wb_rd) begin
            return wb_data;
        end else begin
            return regs[a];
        end
    endfunction

    always_comb begin
        rd1 = read_port(rs1);
        rd2 = read_port(rs2);
    end

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`default_nettype none

module decode_stage (
    input  wire                              clk,
    input  wire                              rst,
    input  wire  [cpu_pkg::xlen-1:0]         pc_id,
    input  wire  [cpu_pkg::xlen-1:0]         instr_id,
    input  wire                              wb_we,
    input  wire  [cpu_pkg::reg_addr_w-1:0]   wb_rd,
    input  wire  [cpu_pkg::xlen-1:0]         wb_data,
    hazard_if.dec                            hz,
    output logic [cpu_pkg::alu_op_w-1:0]     alu_op,
    output logic                             alu_src_imm,
    output logic                             is_load,
    output logic                             is_store,
    output logic                             is_branch_ne,
    output logic                             is_branch,
    output logic                             is_jal,
    output logic [cpu_pkg::wb_sel_w-1:0]     wb_sel,
    output logic                             reg_write,
    output logic [cpu_pkg::xlen-1:0]         pc_ex,
    output logic [cpu_pkg::xlen-1:0]         imm_ex,
    output logic [cpu_pkg::xlen-1:0]         rs1_val_ex,
    output logic [cpu_pkg::xlen-1:0]         rs2_val_ex,
    output logic [cpu_pkg::reg_addr_w-1:0]   rd_ex_idx,
    output logic [cpu_pkg::reg_addr_w-1:0]   rs1_ex_idx,
    output logic [cpu_pkg::reg_addr_w-1:0]   rs2_ex_idx
);

    cpu_pkg::instr_t ins;
    logic [cpu_pkg::alu_op_w-1:0] d_alu_op;
    logic [cpu_pkg::wb_sel_w-1:0] d_wb_sel;
    logic [cpu_pkg::xlen-1:0]     d_imm;
    logic [cpu_pkg::xlen-1:0]     rd1;
    logic [cpu_pkg::xlen-1:0]     rd2;
    logic d_src_imm, d_load, d_store, d_branch, d_jal, d_write, d_uses_rs2;

    assign ins = instr_id;

    // --------------------------------------------------
    // control and immediate decode
    always_comb begin
        d_alu_op   = cpu_pkg::alu_add;
        d_wb_sel   = cpu_pkg::wb_alu;
        d_imm      = '0;
        d_src_imm  = 1'b0;
        d_load     = 1'b0;
        d_store    = 1'b0;
        d_branch   = 1'b0;
        d_jal      = 1'b0;
        d_write    = 1'b0;
        d_uses_rs2 = 1'b0;
        case (ins.r_fmt.opcode)
            cpu_pkg::op_reg: begin
                d_write    = 1'b1;
                d_uses_rs2 = 1'b1;
                case (ins.r_fmt.funct3)
                    3'b000:  d_alu_op = ins.r_fmt.funct7[5] ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
                    3'b010:  d_alu_op = cpu_pkg::alu_slt;
                    3'b100:  d_alu_op = cpu_pkg::alu_xor;
                    3'b110:  d_alu_op = cpu_pkg::alu_or;
                    default: d_alu_op = cpu_pkg::alu_and;
                endcase
            end
            cpu_pkg::op_imm, cpu_pkg::op_load: begin
                d_imm     = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
                d_src_imm = 1'b1;
                d_write   = 1'b1;
                d_load    = (ins.r_fmt.opcode == cpu_pkg::op_load);
                d_wb_sel  = d_load ? cpu_pkg::wb_mem : cpu_pkg::wb_alu;
            end
            cpu_pkg::op_lui: begin
                d_imm     = {instr_id[31:12], 12'b0};
                d_alu_op  = cpu_pkg::alu_pass_b;
                d_src_imm = 1'b1;
                d_write   = 1'b1;
            end
            cpu_pkg::op_store: begin
                d_imm      = {{20{ins.s_fmt.imm_hi[6]}}, ins.s_fmt.imm_hi, ins.s_fmt.imm_lo};
                d_src_imm  = 1'b1;
                d_store    = 1'b1;
                d_uses_rs2 = 1'b1;
            end
            cpu_pkg::op_branch: begin
                d_imm      = {{19{ins.b_fmt.imm_12}}, ins.b_fmt.imm_12, ins.b_fmt.imm_11,
                              ins.b_fmt.imm_10_5, ins.b_fmt.imm_4_1, 1'b0};
                d_branch   = 1'b1;
                d_uses_rs2 = 1'b1;
            end
            cpu_pkg::op_jal: begin
                d_imm    = {{11{instr_id[31]}}, instr_id[31], instr_id[19:12],
                            instr_id[20], instr_id[30:21], 1'b0};
                d_jal    = 1'b1;
                d_write  = 1'b1;
                d_wb_sel = cpu_pkg::wb_link;
            end
            default: ;
        endcase
    end

    assign hz.rs1_id      = ins.r_fmt.rs1;
    assign hz.rs2_id      = ins.r_fmt.rs2;
    assign hz.id_uses_rs2 = d_uses_rs2;

    reg_file u_reg_file (
        .clk     (clk),
        .rst     (rst),
        .rs1     (ins.r_fmt.rs1),
        .rs2     (ins.r_fmt.rs2),
        .wb_we   (wb_we),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .rd1     (rd1),
        .rd2     (rd2)
    );

    // --------------------------------------------------
    // decode/execute register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {is_load, is_store, is_branch, is_jal, reg_write} <= '0;
        end else if (hz.stall || hz.flush) begin
            {is_load, is_store, is_branch, is_jal, reg_write} <= '0;
        end else begin
            {is_load, is_store, is_branch, is_jal, reg_write} <=
                {d_load, d_store, d_branch, d_jal, d_write};
        end
    end

    always_ff @(posedge clk) begin
        alu_op       <= d_alu_op;
        alu_src_imm  <= d_src_imm;
        is_branch_ne <= ins.b_fmt.funct3[0];
        wb_sel       <= d_wb_sel;
        pc_ex        <= pc_id;
        imm_ex       <= d_imm;
        rs1_val_ex   <= rd1;
        rs2_val_ex   <= rd2;
        rd_ex_idx    <= ins.r_fmt.rd;
        rs1_ex_idx   <= ins.r_fmt.rs1;
        rs2_ex_idx   <= ins.r_fmt.rs2;
    end

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
`default_nettype none

module execute_stage (
    input  wire                              clk,
    input  wire                              rst,
    input  wire  [cpu_pkg::alu_op_w-1:0]     alu_op,
    input  wire                              alu_src_imm,
    input  wire                              is_load,
    input  wire                              is_store,
    input  wire                              is_branch_ne,
    input  wire                              is_branch,
    input  wire                              is_jal,
    input  wire  [cpu_pkg::wb_sel_w-1:0]     wb_sel,
    input  wire                              reg_write,
    input  wire  [cpu_pkg::xlen-1:0]         pc_ex,
    input  wire  [cpu_pkg::xlen-1:0]         imm_ex,
    input  wire  [cpu_pkg::xlen-1:0]         rs1_val_ex,
    input  wire  [cpu_pkg::xlen-1:0]         rs2_val_ex,
    input  wire  [cpu_pkg::reg_addr_w-1:0]   rd_ex_idx,
    input  wire  [cpu_pkg::reg_addr_w-1:0]   rs1_ex_idx,
    input  wire  [cpu_pkg::reg_addr_w-1:0]   rs2_ex_idx,
    input  wire  [cpu_pkg::xlen-1:0]         mem_fwd_data,
    input  wire  [cpu_pkg::xlen-1:0]         wb_data,
    hazard_if.ex                             hz,
    output logic [cpu_pkg::xlen-1:0]         redirect_pc,
    output logic [cpu_pkg::xlen-1:0]         alu_res_mem,
    output logic [cpu_pkg::xlen-1:0]         store_data_mem,
    output logic [cpu_pkg::xlen-1:0]         link_mem,
    output logic                             is_load_mem,
    output logic                             is_store_mem,
    output logic [cpu_pkg::wb_sel_w-1:0]     wb_sel_mem,
    output logic [cpu_pkg::reg_addr_w-1:0]   rd_mem_idx,
    output logic                             reg_write_mem
);

    logic [cpu_pkg::xlen-1:0] op_a;
    logic [cpu_pkg::xlen-1:0] op_b;
    logic [cpu_pkg::xlen-1:0] alu_b;
    logic [cpu_pkg::xlen-1:0] alu_res;
    logic                     taken;

    function automatic logic [cpu_pkg::xlen-1:0] fwd_mux(
        input logic [cpu_pkg::fwd_sel_w-1:0] sel,
        input logic [cpu_pkg::xlen-1:0]      reg_val,
        input logic [cpu_pkg::xlen-1:0]      mem_val,
        input logic [cpu_pkg::xlen-1:0]      wb_val
    );
        case (sel)
            cpu_pkg::fwd_mem: return mem_val;
            cpu_pkg::fwd_wb:  return wb_val;
            default:          return reg_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(hz.fwd_a, rs1_val_ex, mem_fwd_data, wb_data);
    assign op_b  = fwd_mux(hz.fwd_b, rs2_val_ex, mem_fwd_data, wb_data);
    assign alu_b = alu_src_imm ? imm_ex : op_b;

    // --------------------------------------------------
    // alu
    always_comb begin
        case (alu_op)
            cpu_pkg::alu_sub:    alu_res = op_a - alu_b;
            cpu_pkg::alu_and:    alu_res = op_a & alu_b;
            cpu_pkg::alu_or:     alu_res = op_a | alu_b;
            cpu_pkg::alu_xor:    alu_res = op_a ^ alu_b;
            cpu_pkg::alu_slt:    alu_res = {{(cpu_pkg::xlen-1){1'b0}},
                                            ($signed(op_a) < $signed(alu_b))};
            cpu_pkg::alu_pass_b: alu_res = alu_b;
            default:             alu_res = op_a + alu_b;
        endcase
    end

    // beq or bne, decided on forwarded operands
    assign taken       = is_jal || (is_branch && ((op_a == op_b) != is_branch_ne));
    assign redirect_pc = pc_ex + imm_ex;

    assign hz.redirect = taken;
    assign hz.rd_ex    = rd_ex_idx;
    assign hz.load_ex  = is_load;
    assign hz.rs1_ex   = rs1_ex_idx;
    assign hz.rs2_ex   = rs2_ex_idx;

    // --------------------------------------------------
    // execute/memory register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            is_load_mem   <= 1'b0;
            is_store_mem  <= 1'b0;
            reg_write_mem <= 1'b0;
        end else begin
            is_load_mem   <= is_load;
            is_store_mem  <= is_store;
            reg_write_mem <= reg_write;
        end
    end

    always_ff @(posedge clk) begin
        alu_res_mem    <= alu_res;
        store_data_mem <= op_b;
        link_mem       <= pc_ex + cpu_pkg::xlen'(4);
        wb_sel_mem     <= wb_sel;
        rd_mem_idx     <= rd_ex_idx;
    end

endmodule

`default_nettype wire

//--- hdl/memory_stage.sv
`default_nettype none

module memory_stage (
    input  wire                              clk,
    input  wire                              rst,
    input  wire  [cpu_pkg::xlen-1:0]         alu_res_mem,
    input  wire  [cpu_pkg::xlen-1:0]         store_data_mem,
    input  wire  [cpu_pkg::xlen-1:0]         link_mem,
    input  wire                              is_load_mem,
    input  wire                              is_store_mem,
    input  wire  [cpu_pkg::wb_sel_w-1:0]     wb_sel_mem,
    input  wire  [cpu_pkg::reg_addr_w-1:0]   rd_mem_idx,
    input  wire                              reg_write_mem,
    input  wire  [cpu_pkg::xlen-1:0]         dm_rdata,
    hazard_if.mem                            hz,
    output logic                             dm_cs,
    output logic                             dm_oe,
    output logic [cpu_pkg::mem_addr_w-1:0]   dm_addr,
    output logic [3:0]                       dm_web,
    output logic [cpu_pkg::xlen-1:0]         dm_wdata,
    output logic [cpu_pkg::xlen-1:0]         mem_fwd_data,
    output logic                             wb_we,
    output logic [cpu_pkg::reg_addr_w-1:0]   wb_rd,
    output logic [cpu_pkg::xlen-1:0]         wb_data
);

    // --------------------------------------------------
    // data memory port, word accesses only
    assign dm_cs    = is_load_mem || is_store_mem;
    assign dm_oe    = is_load_mem;
    assign dm_addr  = alu_res_mem[cpu_pkg::mem_addr_w+1:2];
    // active-low write strobes, all lanes together
    assign dm_web   = is_store_mem ? 4'b0000 : 4'b1111;
    assign dm_wdata = store_data_mem;

    // result seen by execute for forwarding
    always_comb begin
        case (wb_sel_mem)
            cpu_pkg::wb_mem:  mem_fwd_data = dm_rdata;
            cpu_pkg::wb_link: mem_fwd_data = link_mem;
            default:          mem_fwd_data = alu_res_mem;
        endcase
    end

    // --------------------------------------------------
    // memory/writeback register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= reg_write_mem;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= rd_mem_idx;
        wb_data <= mem_fwd_data;
    end

    assign hz.rd_mem = rd_mem_idx;
    assign hz.we_mem = reg_write_mem;
    assign hz.rd_wb  = wb_rd;
    assign hz.we_wb  = wb_we;

endmodule

`default_nettype wire

//--- hdl/cpu_core.sv
`default_nettype none

module cpu_core (
    input  wire                              clk,
    input  wire                              rst,
    input  wire  [cpu_pkg::xlen-1:0]         im_rdata,
    input  wire  [cpu_pkg::xlen-1:0]         dm_rdata,
    output logic [cpu_pkg::mem_addr_w-1:0]   im_addr,
    output logic                             dm_cs,
    output logic                             dm_oe,
    output logic [cpu_pkg::mem_addr_w-1:0]   dm_addr,
    output logic [3:0]                       dm_web,
    output logic [cpu_pkg::xlen-1:0]         dm_wdata
);

    hazard_if hz ();

    logic [cpu_pkg::xlen-1:0]       redirect_pc, pc_id, instr_id;
    logic [cpu_pkg::alu_op_w-1:0]   alu_op;
    logic [cpu_pkg::wb_sel_w-1:0]   wb_sel, wb_sel_mem;
    logic [cpu_pkg::xlen-1:0]       pc_ex, imm_ex, rs1_val_ex, rs2_val_ex;
    logic [cpu_pkg::reg_addr_w-1:0] rd_ex_idx, rs1_ex_idx, rs2_ex_idx, rd_mem_idx, wb_rd;
    logic [cpu_pkg::xlen-1:0]       alu_res_mem, store_data_mem, link_mem;
    logic [cpu_pkg::xlen-1:0]       mem_fwd_data, wb_data;
    logic alu_src_imm, is_load, is_store, is_branch_ne, is_branch, is_jal, reg_write;
    logic is_load_mem, is_store_mem, reg_write_mem, wb_we;

    pipe_control u_pipe_control (.hz(hz));

    fetch_stage u_fetch (
        .clk(clk), .rst(rst), .im_rdata(im_rdata), .redirect_pc(redirect_pc), .hz(hz),
        .im_addr(im_addr), .pc_id(pc_id), .instr_id(instr_id)
    );

    decode_stage u_decode (
        .clk(clk), .rst(rst), .pc_id(pc_id), .instr_id(instr_id),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data), .hz(hz),
        .alu_op(alu_op), .alu_src_imm(alu_src_imm), .is_load(is_load), .is_store(is_store),
        .is_branch_ne(is_branch_ne), .is_branch(is_branch), .is_jal(is_jal),
        .wb_sel(wb_sel), .reg_write(reg_write), .pc_ex(pc_ex), .imm_ex(imm_ex),
        .rs1_val_ex(rs1_val_ex), .rs2_val_ex(rs2_val_ex), .rd_ex_idx(rd_ex_idx),
        .rs1_ex_idx(rs1_ex_idx), .rs2_ex_idx(rs2_ex_idx)
    );

    execute_stage u_execute (
        .clk(clk), .rst(rst), .alu_op(alu_op), .alu_src_imm(alu_src_imm),
        .is_load(is_load), .is_store(is_store), .is_branch_ne(is_branch_ne),
        .is_branch(is_branch), .is_jal(is_jal), .wb_sel(wb_sel), .reg_write(reg_write),
        .pc_ex(pc_ex), .imm_ex(imm_ex), .rs1_val_ex(rs1_val_ex), .rs2_val_ex(rs2_val_ex),
        .rd_ex_idx(rd_ex_idx), .rs1_ex_idx(rs1_ex_idx), .rs2_ex_idx(rs2_ex_idx),
        .mem_fwd_data(mem_fwd_data), .wb_data(wb_data), .hz(hz),
        .redirect_pc(redirect_pc), .alu_res_mem(alu_res_mem),
        .store_data_mem(store_data_mem), .link_mem(link_mem), .is_load_mem(is_load_mem),
        .is_store_mem(is_store_mem), .wb_sel_mem(wb_sel_mem), .rd_mem_idx(rd_mem_idx),
        .reg_write_mem(reg_write_mem)
    );

    memory_stage u_memory (
        .clk(clk), .rst(rst), .alu_res_mem(alu_res_mem), .store_data_mem(store_data_mem),
        .link_mem(link_mem), .is_load_mem(is_load_mem), .is_store_mem(is_store_mem),
        .wb_sel_mem(wb_sel_mem), .rd_mem_idx(rd_mem_idx), .reg_write_mem(reg_write_mem),
        .dm_rdata(dm_rdata), .hz(hz), .dm_cs(dm_cs), .dm_oe(dm_oe), .dm_addr(dm_addr),
        .dm_web(dm_web), .dm_wdata(dm_wdata), .mem_fwd_data(mem_fwd_data),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data)
    );

endmodule

`default_nettype wire

//--- tests/cpu_core_checker.sv
`default_nettype none

module cpu_core_checker (
    input wire                             clk,
    input wire                             rst,
    input wire [cpu_pkg::mem_addr_w-1:0]   im_addr,
    input wire                             dm_cs,
    input wire                             dm_oe,
    input wire [3:0]                       dm_web
);

    timeunit 1ns;
    timeprecision 100ps;

    // number of failed properties so far
    int error_count = 0;

    // --------------------------------------------------
    // data memory port

    reset_idle: assert property (@(posedge clk) rst |-> (!dm_cs && dm_web == 4'hf))
        else begin
            $error("data memory port active while in reset");
            error_count++;
        end

    // read enable only inside a selected access
    read_in_access: assert property (@(posedge clk) disable iff (rst) dm_oe |-> dm_cs)
        else begin
            $error("dm_oe high without dm_cs");
            error_count++;
        end

    write_in_access: assert property (@(posedge clk) disable iff (rst)
        (dm_web != 4'hf) |-> (dm_cs && !dm_oe))
        else begin
            $error("write strobe without dm_cs or together with dm_oe");
            error_count++;
        end

    // --------------------------------------------------
    // instruction fetch port

    fetch_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(im_addr))
        else begin
            $error("im_addr unknown after reset");
            error_count++;
        end

endmodule

bind cpu_core cpu_core_checker u_checker (
    .clk(clk), .rst(rst), .im_addr(im_addr), .dm_cs(dm_cs), .dm_oe(dm_oe), .dm_web(dm_web)
);

`default_nettype wire

//--- tests/cpu_core_tb.sv
`default_nettype none

module cpu_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int store_timeout = 400;

    logic                             clk = 1'b1;
    logic                             rst = 1'b0;
    logic [cpu_pkg::xlen-1:0]         im_rdata;
    logic [cpu_pkg::xlen-1:0]         dm_rdata;
    logic [cpu_pkg::mem_addr_w-1:0]   im_addr;
    logic                             dm_cs;
    logic                             dm_oe;
    logic [cpu_pkg::mem_addr_w-1:0]   dm_addr;
    logic [3:0]                       dm_web;
    logic [cpu_pkg::xlen-1:0]         dm_wdata;

    logic [cpu_pkg::xlen-1:0]         imem [0:255];
    logic [cpu_pkg::xlen-1:0]         dmem [0:255];
    logic [cpu_pkg::xlen-1:0]         exp_data [$];
    logic [cpu_pkg::mem_addr_w-1:0]   exp_addr [$];
    int                               next_word;

    always #10 clk = ~clk;

    cpu_core uut (
        .clk(clk), .rst(rst), .im_rdata(im_rdata), .dm_rdata(dm_rdata),
        .im_addr(im_addr), .dm_cs(dm_cs), .dm_oe(dm_oe), .dm_addr(dm_addr),
        .dm_web(dm_web), .dm_wdata(dm_wdata)
    );

    // --------------------------------------------------
    // memory models, both read in the same cycle
    assign im_rdata = imem[im_addr];
    // inverted word unless a read is enabled
    assign dm_rdata = (dm_cs && dm_oe) ? dmem[dm_addr] : ~dmem[dm_addr];

    always @(posedge clk) begin
        if (dm_cs && dm_web == 4'h0) begin
            dmem[dm_addr] <= dm_wdata;
        end
    end

    // --------------------------------------------------
    // instruction encoding
    function automatic logic [31:0] reg_word(input logic [6:0] f7, input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, cpu_pkg::op_reg};
    endfunction

    function automatic logic [31:0] imm_word(input logic [6:0] op, input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
            input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpu_pkg::op_branch};
    endfunction

    function automatic logic [31:0] jump_word(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, cpu_pkg::op_jal};
    endfunction

    task automatic place(input logic [31:0] word);
        imem[next_word] = word;
        next_word++;
    endtask

    // sw rs2 to the next free slot, x0 as base
    task automatic store_and_expect(input logic [4:0] rs2, input logic [31:0] value);
        logic [11:0] off;
        off = 12'h100 + 12'(4 * exp_data.size());
        place({off[11:5], rs2, 5'd0, 3'b010, off[4:0], cpu_pkg::op_store});
        exp_data.push_back(value);
        exp_addr.push_back(cpu_pkg::mem_addr_w'(off >> 2));
    endtask

    task automatic load_program(input logic [11:0] a, input logic [11:0] b);
        logic [31:0] r1, r2, r3, r4, r5, r6, r7, r8, r10, link;
        logic [19:0] upper;
        logic [11:0] spill;
        // nop fill carries its own word index
        for (int i = 0; i < 256; i++) begin
            imem[i] = imm_word(cpu_pkg::op_imm, 3'b000, 5'd0, 5'd0, 12'(i));
            dmem[i] = 32'hc0de_0000 | 32'(i);
        end
        r1 = {{20{a[11]}}, a};
        r2 = {{20{b[11]}}, b};
        r3 = r1 + r2;
        r4 = r3 - r1;
        r5 = r4 & r3;
        r6 = r5 | r4;
        r7 = r6 ^ r5;
        r8 = ($signed(r7) < $signed(r6)) ? 32'd1 : 32'd0;
        r10 = r1 + r7;
        upper = {a, b[7:0]};
        next_word = 0;
        // back-to-back alu chain
        place(imm_word(cpu_pkg::op_imm, 3'b000, 5'd1, 5'd0, a));
        place(imm_word(cpu_pkg::op_imm, 3'b000, 5'd2, 5'd0, b));
        place(reg_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        place(reg_word(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
        place(reg_word(7'h00, 3'b111, 5'd5, 5'd4, 5'd3));
        place(reg_word(7'h00, 3'b110, 5'd6, 5'd5, 5'd4));
        place(reg_word(7'h00, 3'b100, 5'd7, 5'd6, 5'd5));
        place(reg_word(7'h00, 3'b010, 5'd8, 5'd7, 5'd6));
        store_and_expect(5'd3, r3);
        store_and_expect(5'd4, r4);
        store_and_expect(5'd5, r5);
        store_and_expect(5'd6, r6);
        store_and_expect(5'd7, r7);
        store_and_expect(5'd8, r8);
        // load followed by its user
        spill = 12'h100 + 12'(4 * exp_data.size());
        store_and_expect(5'd1, r1);
        place(imm_word(cpu_pkg::op_load, 3'b010, 5'd9, 5'd0, spill));
        place(reg_word(7'h00, 3'b000, 5'd10, 5'd9, 5'd7));
        store_and_expect(5'd10, r10);
        // bne falls through, beq skips the +100
        place(imm_word(cpu_pkg::op_imm, 3'b000, 5'd11, 5'd0, 12'd5));
        place(branch_word(3'b001, 5'd1, 5'd1, 13'd8));
        place(imm_word(cpu_pkg::op_imm, 3'b000, 5'd11, 5'd11, 12'd1));
        place(branch_word(3'b000, 5'd11, 5'd11, 13'd8));
        place(imm_word(cpu_pkg::op_imm, 3'b000, 5'd11, 5'd11, 12'd100));
        store_and_expect(5'd11, 32'd6);
        // jal over one instruction
        link = 32'(next_word * 4 + 4);
        place(jump_word(5'd12, 21'd8));
        place(imm_word(cpu_pkg::op_imm, 3'b000, 5'd12, 5'd0, 12'h7ff));
        store_and_expect(5'd12, link);
        // lui, then a write to x0 right before storing x0
        place({upper, 5'd13, cpu_pkg::op_lui});
        store_and_expect(5'd13, {upper, 12'h000});
        place(imm_word(cpu_pkg::op_imm, 3'b000, 5'd0, 5'd1, 12'h123));
        store_and_expect(5'd0, 32'd0);
        // park in a self loop
        place(jump_word(5'd0, 21'd0));
    endtask

    // --------------------------------------------------
    // checks
    task automatic stop_with_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_store();
        assert (dm_wdata == exp_data[0]) else begin
            $display("[FAIL] dm_wdata 0x%h expected 0x%h dm_addr 0x%h",
                     dm_wdata, exp_data[0], dm_addr);
            stop_with_failure();
        end
        assert (dm_addr == exp_addr[0]) else begin
            $display("[FAIL] dm_addr 0x%h expected 0x%h dm_wdata 0x%h",
                     dm_addr, exp_addr[0], dm_wdata);
            stop_with_failure();
        end
        void'(exp_data.pop_front());
        void'(exp_addr.pop_front());
    endtask

    // port values are stable between rising edges
    always @(negedge clk) begin
        if (uut.u_checker.error_count != 0) begin
            $display("an assertion on the memory port protocol fired");
            stop_with_failure();
        end else if (!rst && dm_cs && dm_web == 4'h0) begin
            if (exp_data.size() == 0) begin
                $display("unexpected store to word address 0x%h", dm_addr);
                stop_with_failure();
            end else begin
                check_store();
            end
        end
    end

    initial begin
        int          seed_ret;
        int          cycles;
        logic [11:0] a;
        logic [11:0] b;
        seed_ret = $urandom(32'h9ffbe184);
        a = 12'($urandom);
        b = 12'($urandom);
        load_program(a, b);
        @(negedge clk);
        rst = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        cycles = 0;
        while (exp_data.size() != 0 && cycles < store_timeout) begin
            @(posedge clk);
            cycles++;
        end
        @(negedge clk);
        if (exp_data.size() != 0) begin
            $display("the final store never came within %0d cycles", store_timeout);
            stop_with_failure();
        end else if (uut.u_checker.error_count != 0) begin
            $display("an assertion on the memory port protocol fired");
            stop_with_failure();
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- cpu_core.f
hdl/cpu_pkg.sv
hdl/hazard_if.sv
hdl/pipe_control.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/cpu_core.sv
tests/cpu_core_checker.sv
tests/cpu_core_tb.sv
